// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  shamt_t;

    ////////////////////////////////////////////////////////////
    // major opcodes, ins[31:26]
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OPCODE_SPECIAL = 6'b000000;
    localparam logic [5:0] OPCODE_REGIMM  = 6'b000001;
    localparam logic [5:0] OPCODE_BEQ     = 6'b000100;
    localparam logic [5:0] OPCODE_BNE     = 6'b000101;
    localparam logic [5:0] OPCODE_BLEZ    = 6'b000110;
    localparam logic [5:0] OPCODE_BGTZ    = 6'b000111;
    localparam logic [5:0] OPCODE_ADDI    = 6'b001000;
    localparam logic [5:0] OPCODE_ADDIU   = 6'b001001;
    localparam logic [5:0] OPCODE_SLTI    = 6'b001010;
    localparam logic [5:0] OPCODE_SLTIU   = 6'b001011;
    localparam logic [5:0] OPCODE_ANDI    = 6'b001100;
    localparam logic [5:0] OPCODE_ORI     = 6'b001101;
    localparam logic [5:0] OPCODE_XORI    = 6'b001110;
    localparam logic [5:0] OPCODE_AUI     = 6'b001111;

    // R-type function codes, ins[5:0]
    localparam logic [5:0] FUNCT_SLL  = 6'b000000;
    localparam logic [5:0] FUNCT_SRL  = 6'b000010;
    localparam logic [5:0] FUNCT_SRA  = 6'b000011;
    localparam logic [5:0] FUNCT_SLLV = 6'b000100;
    localparam logic [5:0] FUNCT_SRLV = 6'b000110;
    localparam logic [5:0] FUNCT_SRAV = 6'b000111;
    localparam logic [5:0] FUNCT_ADD  = 6'b100000;
    localparam logic [5:0] FUNCT_ADDU = 6'b100001;
    localparam logic [5:0] FUNCT_SUB  = 6'b100010;
    localparam logic [5:0] FUNCT_SUBU = 6'b100011;
    localparam logic [5:0] FUNCT_AND  = 6'b100100;
    localparam logic [5:0] FUNCT_OR   = 6'b100101;
    localparam logic [5:0] FUNCT_XOR  = 6'b100110;
    localparam logic [5:0] FUNCT_NOR  = 6'b100111;
    localparam logic [5:0] FUNCT_SLT  = 6'b101010;
    localparam logic [5:0] FUNCT_SLTU = 6'b101011;

    // regimm branches, selected by rt
    localparam logic [4:0] RT_BLTZ = 5'b00000;
    localparam logic [4:0] RT_BGEZ = 5'b00001;

    typedef enum logic [3:0] {
        ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_OR,
        ALU_OP_XOR, ALU_OP_NOR, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA,
        ALU_OP_SLLV, ALU_OP_SRLV, ALU_OP_SRAV
    } alu_op_t;

    // nop means operand b is rt
    typedef enum logic [1:0] {
        EXT_OP_NOP, EXT_OP_ZE, EXT_OP_SE, EXT_OP_LS
    } ext_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_GEZ, BR_LTZ
    } branch_op_t;

endpackage

`default_nettype wire

// ==== verilog/mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     ins_valid,
    input  wire mips_pkg::word_t    ins,
    output logic                    dec_valid,
    output logic                    reg_wr,
    output logic                    illegal,
    output mips_pkg::alu_op_t       alu_op,
    output mips_pkg::ext_op_t       ext_op,
    output mips_pkg::branch_op_t    branch_op,
    output mips_pkg::imm_t          imm,
    output mips_pkg::shamt_t        shamt,
    output mips_pkg::reg_addr_t     rs_addr,
    output mips_pkg::reg_addr_t     rt_addr,
    output mips_pkg::reg_addr_t     dst_addr
);

    logic [5:0]           opcode;
    logic [5:0]           funct;
    mips_pkg::reg_addr_t  rs_f;
    mips_pkg::reg_addr_t  rt_f;
    mips_pkg::reg_addr_t  rd_f;

    mips_pkg::alu_op_t    alu_d;
    mips_pkg::ext_op_t    ext_d;
    mips_pkg::branch_op_t br_d;
    mips_pkg::reg_addr_t  dst_d;
    logic                 wr_d;
    logic                 ill_d;

    assign opcode = ins[31:26];
    assign rs_f   = ins[25:21];
    assign rt_f   = ins[20:16];
    assign rd_f   = ins[15:11];
    assign funct  = ins[5:0];

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_d = mips_pkg::ALU_OP_ADD;
        ext_d = mips_pkg::EXT_OP_NOP;
        br_d  = mips_pkg::BR_NONE;
        dst_d = rt_f;
        wr_d  = 1'b0;
        ill_d = 1'b0;
        case (opcode)
            mips_pkg::OPCODE_SPECIAL: begin
                dst_d = rd_f;
                wr_d  = 1'b1;
                case (funct)
                    mips_pkg::FUNCT_SLL:  alu_d = mips_pkg::ALU_OP_SLL;
                    mips_pkg::FUNCT_SRL:  alu_d = mips_pkg::ALU_OP_SRL;
                    mips_pkg::FUNCT_SRA:  alu_d = mips_pkg::ALU_OP_SRA;
                    mips_pkg::FUNCT_SLLV: alu_d = mips_pkg::ALU_OP_SLLV;
                    mips_pkg::FUNCT_SRLV: alu_d = mips_pkg::ALU_OP_SRLV;
                    mips_pkg::FUNCT_SRAV: alu_d = mips_pkg::ALU_OP_SRAV;
                    // no overflow trap, add acts as addu
                    mips_pkg::FUNCT_ADD,
                    mips_pkg::FUNCT_ADDU: alu_d = mips_pkg::ALU_OP_ADD;
                    mips_pkg::FUNCT_SUB,
                    mips_pkg::FUNCT_SUBU: alu_d = mips_pkg::ALU_OP_SUB;
                    mips_pkg::FUNCT_AND:  alu_d = mips_pkg::ALU_OP_AND;
                    mips_pkg::FUNCT_OR:   alu_d = mips_pkg::ALU_OP_OR;
                    mips_pkg::FUNCT_XOR:  alu_d = mips_pkg::ALU_OP_XOR;
                    mips_pkg::FUNCT_NOR:  alu_d = mips_pkg::ALU_OP_NOR;
                    mips_pkg::FUNCT_SLT:  alu_d = mips_pkg::ALU_OP_SLT;
                    mips_pkg::FUNCT_SLTU: alu_d = mips_pkg::ALU_OP_SLTU;
                    default: begin
                        wr_d  = 1'b0;
                        ill_d = 1'b1;
                    end
                endcase
            end
            mips_pkg::OPCODE_REGIMM: begin
                case (rt_f)
                    mips_pkg::RT_BGEZ: br_d = mips_pkg::BR_GEZ;
                    mips_pkg::RT_BLTZ: br_d = mips_pkg::BR_LTZ;
                    // bal, bgezal and the rest
                    default:           ill_d = 1'b1;
                endcase
            end
            mips_pkg::OPCODE_BEQ:  br_d = mips_pkg::BR_EQ;
            mips_pkg::OPCODE_BNE:  br_d = mips_pkg::BR_NE;
            mips_pkg::OPCODE_BLEZ: br_d = mips_pkg::BR_LEZ;
            mips_pkg::OPCODE_BGTZ: br_d = mips_pkg::BR_GTZ;
            mips_pkg::OPCODE_ADDI,
            mips_pkg::OPCODE_ADDIU: begin
                ext_d = mips_pkg::EXT_OP_SE;
                wr_d  = 1'b1;
            end
            mips_pkg::OPCODE_SLTI: begin
                alu_d = mips_pkg::ALU_OP_SLT;
                ext_d = mips_pkg::EXT_OP_SE;
                wr_d  = 1'b1;
            end
            mips_pkg::OPCODE_SLTIU: begin
                alu_d = mips_pkg::ALU_OP_SLTU;
                ext_d = mips_pkg::EXT_OP_SE;
                wr_d  = 1'b1;
            end
            mips_pkg::OPCODE_ANDI: begin
                alu_d = mips_pkg::ALU_OP_AND;
                ext_d = mips_pkg::EXT_OP_ZE;
                wr_d  = 1'b1;
            end
            mips_pkg::OPCODE_ORI: begin
                alu_d = mips_pkg::ALU_OP_OR;
                ext_d = mips_pkg::EXT_OP_ZE;
                wr_d  = 1'b1;
            end
            mips_pkg::OPCODE_XORI: begin
                alu_d = mips_pkg::ALU_OP_XOR;
                ext_d = mips_pkg::EXT_OP_ZE;
                wr_d  = 1'b1;
            end
            // rs + (imm << 16)
            mips_pkg::OPCODE_AUI: begin
                ext_d = mips_pkg::EXT_OP_LS;
                wr_d  = 1'b1;
            end
            default: ill_d = 1'b1;
        endcase
    end

    // control fields
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            reg_wr    <= 1'b0;
            illegal   <= 1'b0;
            branch_op <= mips_pkg::BR_NONE;
        end else begin
            dec_valid <= ins_valid;
            if (ins_valid) begin
                reg_wr    <= wr_d && (dst_d != '0);
                illegal   <= ill_d;
                branch_op <= br_d;
            end
        end
    end

    // operand fields
    always_ff @(posedge clk) begin
        if (ins_valid) begin
            alu_op   <= alu_d;
            ext_op   <= ext_d;
            imm      <= ins[15:0];
            shamt    <= ins[10:6];
            rs_addr  <= rs_f;
            rt_addr  <= rt_f;
            dst_addr <= dst_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
    input  wire mips_pkg::alu_op_t      alu_op,
    input  wire mips_pkg::ext_op_t      ext_op,
    input  wire mips_pkg::branch_op_t   branch_op,
    input  wire mips_pkg::imm_t         imm,
    input  wire mips_pkg::shamt_t       shamt,
    input  wire mips_pkg::word_t        rs_data,
    input  wire mips_pkg::word_t        rt_data,
    output mips_pkg::word_t             result,
    output logic                        branch_en,
    output logic                        branch_taken
);

    mips_pkg::word_t opnd_b;
    logic [4:0]      rs_sh;

    assign rs_sh = rs_data[4:0];

    // second operand, rt or the extended immediate
    always_comb begin
        case (ext_op)
            mips_pkg::EXT_OP_ZE: opnd_b = {16'h0000, imm};
            mips_pkg::EXT_OP_SE: opnd_b = {{16{imm[15]}}, imm};
            mips_pkg::EXT_OP_LS: opnd_b = {imm, 16'h0000};
            default:             opnd_b = rt_data;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            mips_pkg::ALU_OP_ADD:  result = rs_data + opnd_b;
            mips_pkg::ALU_OP_SUB:  result = rs_data - opnd_b;
            mips_pkg::ALU_OP_AND:  result = rs_data & opnd_b;
            mips_pkg::ALU_OP_OR:   result = rs_data | opnd_b;
            mips_pkg::ALU_OP_XOR:  result = rs_data ^ opnd_b;
            mips_pkg::ALU_OP_NOR:  result = ~(rs_data | opnd_b);
            mips_pkg::ALU_OP_SLT:  result = {31'b0, $signed(rs_data) < $signed(opnd_b)};
            mips_pkg::ALU_OP_SLTU: result = {31'b0, rs_data < opnd_b};
            // shifts act on rt
            mips_pkg::ALU_OP_SLL:  result = rt_data << shamt;
            mips_pkg::ALU_OP_SRL:  result = rt_data >> shamt;
            mips_pkg::ALU_OP_SRA:  result = $signed(rt_data) >>> shamt;
            mips_pkg::ALU_OP_SLLV: result = rt_data << rs_sh;
            mips_pkg::ALU_OP_SRLV: result = rt_data >> rs_sh;
            mips_pkg::ALU_OP_SRAV: result = $signed(rt_data) >>> rs_sh;
            default:               result = '0;
        endcase
    end

    // branch compare
    assign branch_en = (branch_op != mips_pkg::BR_NONE);

    always_comb begin
        case (branch_op)
            mips_pkg::BR_EQ:  branch_taken = (rs_data == rt_data);
            mips_pkg::BR_NE:  branch_taken = (rs_data != rt_data);
            mips_pkg::BR_LEZ: branch_taken = ($signed(rs_data) <= 0);
            mips_pkg::BR_GTZ: branch_taken = ($signed(rs_data) > 0);
            mips_pkg::BR_GEZ: branch_taken = ~rs_data[31];
            mips_pkg::BR_LTZ: branch_taken = rs_data[31];
            default:          branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mips_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_result (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         dec_valid,
    input  wire                         reg_wr,
    input  wire                         illegal,
    input  wire mips_pkg::reg_addr_t    dst_addr,
    input  wire mips_pkg::reg_addr_t    rs_addr,
    input  wire mips_pkg::reg_addr_t    rt_addr,
    input  wire mips_pkg::word_t        result,
    input  wire                         branch_en,
    input  wire                         branch_taken,
    output mips_pkg::word_t             rs_data,
    output mips_pkg::word_t             rt_data,
    output logic                        wb_valid,
    output mips_pkg::reg_addr_t         wb_addr,
    output mips_pkg::word_t             wb_data,
    output logic                        branch_valid,
    output logic                        branch_taken_q,
    output logic                        ins_illegal
);

    // r0 is not stored
    mips_pkg::word_t regs [1:31];

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (dec_valid && reg_wr) begin
            regs[dst_addr] <= result;
        end
    end

    // one pulse per decoded instruction at most
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            branch_valid <= 1'b0;
            ins_illegal  <= 1'b0;
        end else begin
            wb_valid     <= dec_valid && reg_wr;
            branch_valid <= dec_valid && branch_en && !illegal;
            ins_illegal  <= dec_valid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr        <= dst_addr;
        wb_data        <= result;
        branch_taken_q <= branch_taken;
    end

endmodule

`default_nettype wire

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         ins_valid,
    input  wire mips_pkg::word_t        ins,
    output logic                        wb_valid,
    output mips_pkg::reg_addr_t         wb_addr,
    output mips_pkg::word_t             wb_data,
    output logic                        branch_valid,
    output logic                        branch_taken,
    output logic                        ins_illegal
);

    ////////////////////////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////////////////////////
    logic                 dec_valid;
    logic                 reg_wr;
    logic                 illegal;
    mips_pkg::alu_op_t    alu_op;
    mips_pkg::ext_op_t    ext_op;
    mips_pkg::branch_op_t branch_op;
    mips_pkg::imm_t       imm;
    mips_pkg::shamt_t     shamt;
    mips_pkg::reg_addr_t  rs_addr;
    mips_pkg::reg_addr_t  rt_addr;
    mips_pkg::reg_addr_t  dst_addr;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    mips_pkg::word_t      result;
    logic                 branch_en;
    logic                 exe_taken;

    mips_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .ins_valid (ins_valid),
        .ins       (ins),
        .dec_valid (dec_valid),
        .reg_wr    (reg_wr),
        .illegal   (illegal),
        .alu_op    (alu_op),
        .ext_op    (ext_op),
        .branch_op (branch_op),
        .imm       (imm),
        .shamt     (shamt),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .dst_addr  (dst_addr)
    );

    mips_execute u_execute (
        .alu_op       (alu_op),
        .ext_op       (ext_op),
        .branch_op    (branch_op),
        .imm          (imm),
        .shamt        (shamt),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .result       (result),
        .branch_en    (branch_en),
        .branch_taken (exe_taken)
    );

    mips_result u_result (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .reg_wr         (reg_wr),
        .illegal        (illegal),
        .dst_addr       (dst_addr),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .result         (result),
        .branch_en      (branch_en),
        .branch_taken   (exe_taken),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .branch_valid   (branch_valid),
        .branch_taken_q (branch_taken),
        .ins_illegal    (ins_illegal)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mips_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core_sva (
    input wire                      clk,
    input wire                      reset,
    input wire                      wb_valid,
    input wire mips_pkg::reg_addr_t wb_addr,
    input wire                      branch_valid,
    input wire                      ins_illegal
);

    logic any_pulse;

    assign any_pulse = wb_valid | branch_valid | ins_illegal;

    // pulses are cleared by reset and stay low one cycle past it
    assert property (@(posedge clk) reset |=> !any_pulse)
        else $error("result pulse high during reset");

    assert property (@(posedge clk) $fell(reset) |=> !any_pulse)
        else $error("result pulse high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset)
        $onehot0({wb_valid, branch_valid, ins_illegal}))
        else $error("more than one result pulse high at once");

    assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_addr != '0)
        else $error("register write reported for register zero");

endmodule

bind mips_core tb_mips_core_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .branch_valid (branch_valid),
    .ins_illegal  (ins_illegal)
);

`default_nettype wire

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam logic [1:0] KIND_NONE = 2'd0;
    localparam logic [1:0] KIND_WB   = 2'd1;
    localparam logic [1:0] KIND_BR   = 2'd2;
    localparam logic [1:0] KIND_ILL  = 2'd3;

    // add addu sub subu and or xor nor slt sltu
    localparam logic [59:0] ALU_FUNCTS = {6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                          6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam logic [35:0] SHIFT_FUNCTS = {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
    // j, jal, cop0, special2, special3, lb, lw, sw
    localparam logic [47:0] BAD_OPS = {6'h02, 6'h03, 6'h10, 6'h1c, 6'h1f, 6'h20, 6'h23, 6'h2b};
    // jr, jalr, syscall, break, mfhi, mult, div, movci
    localparam logic [47:0] BAD_FUNCTS = {6'h08, 6'h09, 6'h0c, 6'h0d,
                                          6'h10, 6'h18, 6'h1a, 6'h01};
    // bltzal, bgezal, bltzl, teqi
    localparam logic [19:0] BAD_RT = {5'h10, 5'h11, 5'h02, 5'h0c};

    typedef struct packed {
        logic [31:0]         tag;
        logic [1:0]          kind;
        mips_pkg::reg_addr_t addr;
        mips_pkg::word_t     data;
        logic                taken;
    } exp_t;

    logic                clk;
    logic                reset;
    logic                ins_valid;
    mips_pkg::word_t     ins;
    logic                wb_valid;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::word_t     wb_data;
    logic                branch_valid;
    logic                branch_taken;
    logic                ins_illegal;

    mips_pkg::word_t shadow [32];
    exp_t            pending [$];
    logic [31:0]     rng_state;
    logic [31:0]     cyc;
    int              mismatches;
    int              failures;

    mips_core DUT (
        .clk          (clk),
        .reset        (reset),
        .ins_valid    (ins_valid),
        .ins          (ins),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .ins_illegal  (ins_illegal)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic mips_pkg::word_t rtype(logic [5:0] fn, mips_pkg::reg_addr_t rs,
            mips_pkg::reg_addr_t rt, mips_pkg::reg_addr_t rd, mips_pkg::shamt_t sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t itype(logic [5:0] op, mips_pkg::reg_addr_t rs,
            mips_pkg::reg_addr_t rt, mips_pkg::imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic exp_t predict(mips_pkg::word_t w);
        exp_t            e;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t se;
        logic [4:0]      sh;
        e    = '0;
        a    = shadow[w[25:21]];
        b    = shadow[w[20:16]];
        se   = {{16{w[15]}}, w[15:0]};
        sh   = w[10:6];
        e.kind = KIND_WB;
        e.addr = (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h00: e.data = b << sh;
                    6'h02: e.data = b >> sh;
                    6'h03: e.data = $signed(b) >>> sh;
                    6'h04: e.data = b << a[4:0];
                    6'h06: e.data = b >> a[4:0];
                    6'h07: e.data = $signed(b) >>> a[4:0];
                    6'h20, 6'h21: e.data = a + b;
                    6'h22, 6'h23: e.data = a - b;
                    6'h24: e.data = a & b;
                    6'h25: e.data = a | b;
                    6'h26: e.data = a ^ b;
                    6'h27: e.data = ~(a | b);
                    6'h2a: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: e.data = (a < b) ? 32'd1 : 32'd0;
                    default: e.kind = KIND_ILL;
                endcase
            end
            6'h01: begin
                e.kind  = (w[20:16] == 5'h00 || w[20:16] == 5'h01) ? KIND_BR : KIND_ILL;
                e.taken = (w[20:16] == 5'h01) ? !a[31] : a[31];
            end
            6'h04: {e.kind, e.taken} = {KIND_BR, a == b};
            6'h05: {e.kind, e.taken} = {KIND_BR, a != b};
            6'h06: {e.kind, e.taken} = {KIND_BR, a[31] || a == 0};
            6'h07: {e.kind, e.taken} = {KIND_BR, !a[31] && a != 0};
            6'h08, 6'h09: e.data = a + se;
            6'h0a: e.data = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            6'h0b: e.data = (a < se) ? 32'd1 : 32'd0;
            6'h0c: e.data = a & {16'h0000, w[15:0]};
            6'h0d: e.data = a | {16'h0000, w[15:0]};
            6'h0e: e.data = a ^ {16'h0000, w[15:0]};
            6'h0f: e.data = a + {w[15:0], 16'h0000};
            default: e.kind = KIND_ILL;
        endcase
        if (e.kind == KIND_WB && e.addr == 0) begin
            e.kind = KIND_NONE;
        end
        return e;
    endfunction

    task automatic issue(mips_pkg::word_t w);
        exp_t e;
        @(posedge clk);
        e         = predict(w);
        e.tag     = cyc + 1;
        ins       <= w;
        ins_valid <= 1'b1;
        pending.push_back(e);
        if (e.kind == KIND_WB) begin
            shadow[e.addr] = e.data;
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            ins_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while (pending.size() > 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            failures++;
            $display("timed out with %0d expected pulses never seen", pending.size());
        end
    endtask

    task automatic data_check(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic addr_check(string name, mips_pkg::reg_addr_t got,
            mips_pkg::reg_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic flag_check(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    // pulse for an instruction sampled at edge n shows at edge n+2
    always @(posedge clk) begin : compare_proc
        exp_t e;
        if (!reset) begin
            e = '0;
            if (pending.size() > 0 && pending[0].tag + 2 == cyc) begin
                e = pending.pop_front();
            end
            flag_check("wb_valid", wb_valid, e.kind == KIND_WB);
            flag_check("branch_valid", branch_valid, e.kind == KIND_BR);
            flag_check("ins_illegal", ins_illegal, e.kind == KIND_ILL);
            if (e.kind == KIND_WB && wb_valid) begin
                addr_check("wb_addr", wb_addr, e.addr);
                data_check("wb_data", wb_data, e.data);
            end
            if (e.kind == KIND_BR && branch_valid) begin
                flag_check("branch_taken", branch_taken, e.taken);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        logic [31:0]         r;
        logic [31:0]         v;
        mips_pkg::imm_t      imm;
        mips_pkg::reg_addr_t d;
        mips_pkg::reg_addr_t s;
        mips_pkg::reg_addr_t t;
        logic [2:0]          k;
        clk        = 1'b0;
        reset      = 1'b1;
        ins_valid  = 1'b0;
        ins        = '0;
        cyc        = '0;
        rng_state  = 32'hb57e1b88;
        mismatches = 0;
        failures   = 0;
        d          = 5'd1;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        idle(4);

        // registers read zero after reset
        for (int i = 1; i < 32; i++) begin
            issue(rtype(6'h25, i, 0, i, 0));
        end
        // load every register with ori then aui
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            issue(itype(6'h0d, 0, i, r[15:0]));
            issue(itype(6'h0f, i, i, r[31:16]));
        end
        // register-register ops where every fourth one reads the last destination
        for (int n = 0; n < 200; n++) begin
            r = next_rand();
            s = (n % 4 == 0) ? d : r[25:21];
            issue(rtype(ALU_FUNCTS[(r[31:28] % 10) * 6 +: 6], s, r[20:16], r[15:11], 0));
            d = r[15:11];
        end
        // immediates with boundary values mixed in
        for (int n = 0; n < 120; n++) begin
            r   = next_rand();
            v   = next_rand();
            imm = v[15:0];
            if (n % 8 == 0) begin
                imm = 16'h8000;
            end
            if (n % 8 == 1) begin
                imm = 16'hffff;
            end
            issue(itype(6'h08 + r[2:0], r[25:21], r[20:16], imm));
        end
        for (int n = 0; n < 120; n++) begin
            r = next_rand();
            issue(rtype(SHIFT_FUNCTS[(r[31:28] % 6) * 6 +: 6], r[25:21], r[20:16],
                        r[15:11], r[10:6]));
        end

        // r1..r5 hold zero, -1, one, most negative, most positive
        issue(itype(6'h0d, 0, 1, 16'h0000));
        issue(itype(6'h09, 0, 2, 16'hffff));
        issue(itype(6'h0d, 0, 3, 16'h0001));
        issue(itype(6'h0f, 0, 4, 16'h8000));
        issue(itype(6'h0f, 0, 5, 16'h7fff));
        issue(itype(6'h0d, 5, 5, 16'hffff));
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                issue(itype(6'h04, i, j, 16'h0010));
                issue(itype(6'h05, i, j, 16'h0010));
            end
            issue(itype(6'h06, i, 0, 16'h0010));
            issue(itype(6'h07, i, 0, 16'h0010));
            issue(itype(6'h01, i, 0, 16'h0010));
            issue(itype(6'h01, i, 1, 16'h0010));
        end
        for (int n = 0; n < 120; n++) begin
            r = next_rand();
            k = r[31:29] % 6;
            t = (n % 3 == 0) ? r[25:21] : r[20:16];
            if (k < 4) begin
                issue(itype({3'b000, k} + 6'h04, r[25:21], t, r[15:0]));
            end else begin
                issue(itype(6'h01, r[25:21], {4'b0000, k[0]}, r[15:0]));
            end
        end

        // dropped and unknown encodings
        for (int n = 0; n < 60; n++) begin
            r = next_rand();
            v = next_rand();
            case (n % 3)
                0: v[31:26] = BAD_OPS[r[2:0] * 6 +: 6];
                1: v = {6'h00, v[25:6], BAD_FUNCTS[r[2:0] * 6 +: 6]};
                default: v = {6'h01, v[25:21], BAD_RT[r[1:0] * 5 +: 5], v[15:0]};
            endcase
            issue(v);
        end
        // writes to r0 give no pulse
        for (int n = 0; n < 20; n++) begin
            r = next_rand();
            issue(rtype(ALU_FUNCTS[(r[31:28] % 10) * 6 +: 6], r[25:21], r[20:16], 0, 0));
            issue(itype(6'h08 + r[2:0], r[25:21], 0, r[15:0]));
        end
        // read back every register
        for (int i = 1; i < 32; i++) begin
            issue(rtype(6'h25, i, 0, i, 0));
        end
        drain();
        idle(2);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/mips_pkg.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_result.sv
verilog/mips_core.sv
testbench/tb_mips_core_sva.sv
testbench/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - verilog/mips_pkg.sv
      - verilog/mips_decode.sv
      - verilog/mips_execute.sv
      - verilog/mips_result.sv
      - verilog/mips_core.sv
  - target: test
    files:
      - testbench/tb_mips_core_sva.sv
      - testbench/tb_mips_core.sv
